// ==== design/smc_access_fsm.sv ====
/*
  SMC lite access timing FSM
  Runs one external transfer over a fixed number of wait states,
  holding chip select for the whole transfer and strobing write
  enable in the last cycle
*/
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_access_fsm
(
  input  logic hclk14,
  input  logic n_sys_reset14,
  input  logic xfer_start,    // One-cycle start of a transfer
  input  logic ext_write,
  output logic smc_done,      // Last cycle of the transfer
  output logic ext_cs_n,
  output logic ext_we_n
);

  localparam int unsigned WS = `SMC_WAIT_STATES;
  localparam int unsigned CW = `SMC_WAIT_CNT_W;
  localparam logic [CW-1:0] WS_LOAD = (WS > 0) ? CW'(WS - 1) : '0;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_WAIT,
    ST_STROBE
  } state_e;

  // Straight to strobe when there are no wait states
  localparam state_e START_STATE = (WS == 0) ? ST_STROBE : ST_WAIT;

  state_e        state;
  state_e        state_nxt;
  logic [CW-1:0] wait_cnt;    // Wait cycles left after this one

  // Next state ----------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE   : if (xfer_start) state_nxt = START_STATE;
      ST_WAIT   : if (wait_cnt == '0) state_nxt = ST_STROBE;
      ST_STROBE : state_nxt = xfer_start ? START_STATE : ST_IDLE;
      default   : state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk14 or negedge n_sys_reset14)
  begin
    if (!n_sys_reset14)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (xfer_start)
        wait_cnt <= WS_LOAD;
      else if ((state == ST_WAIT) && (wait_cnt != '0))
        wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // Outputs -------------
  assign smc_done = (state == ST_STROBE);
  assign ext_cs_n = (state == ST_IDLE);
  assign ext_we_n = !((state == ST_STROBE) && ext_write);  // Stores on rising edge

  // FSM must be idle or in its done cycle, so free on the next edge
  a_start_idle : assert property (
    @(posedge hclk14) disable iff (!n_sys_reset14)
    xfer_start |-> ((state == ST_IDLE) || smc_done)
  ) else $error("xfer_start while the FSM is busy");

  // Write strobe inside chip select, a full transfer after its start
  a_we_in_cs : assert property (
    @(posedge hclk14) disable iff (!n_sys_reset14)
    !ext_we_n |-> (!ext_cs_n && $past(xfer_start, WS + 1))
  ) else $error("write enable outside its transfer window");

endmodule

// ==== design/smc_ahb_lite_if.sv ====
/*
  SMC lite AHB-Lite slave front end
  Flags valid address phases, catches misaligned accesses and answers
  them with a two-cycle ERROR, and holds hready low until the memory
  access controller reports the last transfer done
*/
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_ahb_lite_if import smc_pkg::*;
(
  input  logic        hclk14,
  input  logic        n_sys_reset14,
  input  logic        hsel,
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,         // Muxed bus ready
  input  logic        smc_done,       // Last cycle of a transfer
  input  logic        mac_done,       // Transfer is the last of the access
  input  logic [31:0] read_data,
  output smc_req_t    req,
  output logic        new_access,
  output logic [31:0] write_data,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid
);

  logic active_trn;                   // NONSEQ or SEQ
  logic idle_trn;                     // IDLE or BUSY
  logic mis_err;                      // Misaligned address phase
  logic r_ready;                      // Registered ready
  logic r_hresp;                      // Second error cycle pending

  // Decode --------------
  assign active_trn = (htrans == `TRN_NONSEQ) || (htrans == `TRN_SEQ);
  assign idle_trn   = (htrans == `TRN_IDLE) || (htrans == `TRN_BUSY);

  // Request straight from the address phase
  assign req.addr  = haddr;
  assign req.write = hwrite;
  assign req.size  = smc_size_e'(hsize[1:0]);

  // Odd half or word not on a 4-byte boundary
  // Only sampled when the phase is really presented
  assign mis_err = (((hsize[1:0] == SZ_HALF) && haddr[0]) ||
                    ((hsize[1:0] == SZ_WORD) && (haddr[1:0] != 2'b00))) &&
                   active_trn && hsel && hready;

  assign new_access = hsel && active_trn && hready && !mis_err;
  assign smc_valid  = new_access;     // Ack back to the decoder

  // Response ------------
  // First error cycle with ready low, second with ready high
  always_ff @(posedge hclk14 or negedge n_sys_reset14)
  begin
    if (!n_sys_reset14)
    begin
      smc_hresp <= `RSP_OKAY;
      r_hresp   <= 1'b0;
    end
    else
    begin
      r_hresp <= mis_err;
      if (mis_err || r_hresp)
        smc_hresp <= `RSP_ERROR;
      else
        smc_hresp <= `RSP_OKAY;
    end
  end

  // Ready ---------------
  always_ff @(posedge hclk14 or negedge n_sys_reset14)
  begin
    if (!n_sys_reset14)
      r_ready <= 1'b1;
    else if (new_access || mis_err)
      r_ready <= 1'b0;                // Wait states start next cycle
    else if (r_hresp || (smc_done && mac_done))
      r_ready <= 1'b1;                // Error tail or access complete
    else if (hready && (idle_trn || !hsel))
      r_ready <= 1'b1;                // Not ours, zero wait
  end

  // Early release on the final transfer
  assign smc_hready = r_ready || (smc_done && mac_done);

  // Data passes straight through
  assign smc_hrdata = read_data;
  assign write_data = hwdata;

  // An error run is two cycles, ready low then high; a third ERROR
  // cycle may only be the start of a fresh error
  a_err_two_cycle : assert property (
    @(posedge hclk14) disable iff (!n_sys_reset14)
    ((smc_hresp == `RSP_ERROR) && !smc_hready) |=>
      ((smc_hresp == `RSP_ERROR) && smc_hready) ##1
      ((smc_hresp == `RSP_OKAY) || !smc_hready)
  ) else $error("hresp ERROR not a two-cycle response");

endmodule

// ==== design/smc_lite_top.sv ====
/*
  SMC lite top level
  AHB-Lite static memory controller for one 16-bit asynchronous SRAM,
  built from the AHB front end, the access controller and the timing FSM
*/
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_lite_top import smc_pkg::*;
(
  input  logic                   hclk14,
  input  logic                   n_sys_reset14,
  input  logic                   hsel,
  input  logic [31:0]            haddr,
  input  logic [1:0]             htrans,
  input  logic                   hwrite,
  input  logic [2:0]             hsize,
  input  logic [31:0]            hwdata,
  input  logic                   hready,
  output logic [31:0]            smc_hrdata,
  output logic                   smc_hready,
  output logic [1:0]             smc_hresp,
  output logic                   smc_valid,
  output smc_ext_bus_t           ext_bus,
  input  logic [`SMC_EXT_DW-1:0] ext_rdata
);

  smc_req_t               req;
  logic                   new_access;
  logic [31:0]            write_data;
  logic [31:0]            read_data;
  logic                   xfer_start;
  logic                   smc_done;
  logic                   mac_done;
  logic [`SMC_EXT_AW-1:0] ext_addr;
  logic [`SMC_EXT_DW-1:0] ext_wdata;
  logic [1:0]             ext_be_n;
  logic                   ext_write;
  logic                   ext_cs_n;
  logic                   ext_we_n;

  smc_ahb_lite_if u_ahb_if (.*);      // AHB decode and response
  smc_mac         u_mac (.*);         // Transfer split and data lanes
  smc_access_fsm  u_fsm (.*);         // Wait-state timing

  // SRAM pins
  assign ext_bus = '{addr: ext_addr, wdata: ext_wdata, be_n: ext_be_n,
                     we_n: ext_we_n, cs_n: ext_cs_n};

endmodule

// ==== design/smc_mac.sv ====
/*
  SMC lite memory access controller
  Splits each AHB access into one or two 16-bit external transfers,
  drives address, byte lanes and write half, and gathers read halves
  into their AHB lane positions
*/
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_mac import smc_pkg::*;
(
  input  logic                   hclk14,
  input  logic                   n_sys_reset14,
  input  smc_req_t               req,
  input  logic                   new_access,
  input  logic [31:0]            write_data,
  input  logic                   smc_done,
  input  logic [`SMC_EXT_DW-1:0] ext_rdata,
  output logic                   xfer_start,
  output logic                   mac_done,
  output logic [31:0]            read_data,
  output logic [`SMC_EXT_AW-1:0] ext_addr,
  output logic [`SMC_EXT_DW-1:0] ext_wdata,
  output logic [1:0]             ext_be_n,
  output logic                   ext_write
);

  smc_req_t               req_q;      // Latched access
  logic [1:0]             pend_cnt;   // Transfers still to finish
  logic                   hw_sel;     // Upper half of the word
  logic [31:0]            rd_q;       // Halves gathered so far
  logic [`SMC_EXT_DW-1:0] rd_mask;
  logic [`SMC_EXT_DW-1:0] rd_half;

  // Control -------------
  always_ff @(posedge hclk14 or negedge n_sys_reset14)
  begin
    if (!n_sys_reset14)
    begin
      pend_cnt <= 2'd0;
      hw_sel   <= 1'b0;
    end
    else if (new_access)
    begin
      pend_cnt <= (req.size == SZ_WORD) ? 2'd2 : 2'd1;
      hw_sel   <= (req.size == SZ_WORD) ? 1'b0 : req.addr[1];
    end
    else if (smc_done)
    begin
      pend_cnt <= pend_cnt - 2'd1;
      if (pend_cnt == 2'd2)
        hw_sel <= 1'b1;               // Word moves to its upper half
    end
  end

  // Request payload
  always_ff @(posedge hclk14)
  begin
    if (new_access)
      req_q <= req;
  end

  // First transfer with the address phase, second back to back
  assign xfer_start = new_access || (smc_done && (pend_cnt == 2'd2));
  assign mac_done   = (pend_cnt == 2'd1);

  // External bus --------
  assign ext_addr  = {req_q.addr[`SMC_EXT_AW:2], hw_sel};
  assign ext_write = req_q.write;
  assign ext_wdata = hw_sel ? write_data[31:16] : write_data[15:0];

  // One lane for a byte, picked by address bit 0
  always_comb
  begin
    if (req_q.size == SZ_BYTE)
      ext_be_n = req_q.addr[0] ? 2'b01 : 2'b10;
    else
      ext_be_n = 2'b00;
  end

  // Read path -----------
  assign rd_mask = {{8{~ext_be_n[1]}}, {8{~ext_be_n[0]}}};
  assign rd_half = ext_rdata & rd_mask;   // Unread byte stays zero

  // Current half goes live so it is valid with hready
  assign read_data = rd_q | (hw_sel ? {rd_half, 16'h0000} : {16'h0000, rd_half});

  always_ff @(posedge hclk14)
  begin
    if (new_access)
      rd_q <= '0;
    else if (smc_done)
      rd_q <= read_data;
  end

  // A new access may only land on the final done cycle or when quiet
  a_no_overlap : assert property (
    @(posedge hclk14) disable iff (!n_sys_reset14)
    new_access |-> ((pend_cnt == 2'd0) || (mac_done && smc_done))
  ) else $error("new_access while a transfer is pending");

endmodule

// ==== design/smc_pkg.sv ====
/*
  SMC lite types
  Access size, captured AHB request and the external SRAM pin bundle
*/
package smc_pkg;

  `include "smc_defs.svh"

  // Sizes ---------------
  // Matches hsize[1:0] for the sizes the controller supports
  typedef enum logic [1:0]
  {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10
  } smc_size_e;

  // Request -------------
  typedef struct packed
  {
    logic [31:0] addr;            // Byte address from haddr
    logic        write;           // High for a write
    smc_size_e   size;            // Access width
  } smc_req_t;

  // External pins -------
  // All strobes active low
  typedef struct packed
  {
    logic [`SMC_EXT_AW-1:0] addr; // Half-word address
    logic [`SMC_EXT_DW-1:0] wdata;
    logic [1:0]             be_n; // Bit 1 is the upper byte
    logic                   we_n;
    logic                   cs_n;
  } smc_ext_bus_t;

endpackage

// ==== include/smc_defs.svh ====
/*
  SMC lite constants
  Wait-state count, bus widths and the AHB transfer and response codes
  shared by the static memory controller
*/
`ifndef SMC_DEFS_SVH
`define SMC_DEFS_SVH

// Timing --------------
`define SMC_WAIT_STATES 2       // Extra cycles per external transfer
`define SMC_WAIT_CNT_W  4       // Wait counter width

// Widths --------------
`define SMC_EXT_AW 16           // External half-word address
`define SMC_EXT_DW 16           // External data bus

// AHB htrans
`define TRN_IDLE   2'b00
`define TRN_BUSY   2'b01
`define TRN_NONSEQ 2'b10
`define TRN_SEQ    2'b11

// AHB hresp
`define RSP_OKAY  2'b00
`define RSP_ERROR 2'b01

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SMC lite testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f smc_lite.f --top-module tb_smc_lite --Mdir obj_dir -o tb_smc_lite
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_smc_lite > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi
exit 0

// ==== smc_lite.f ====
+incdir+include
design/smc_pkg.sv
design/smc_ahb_lite_if.sv
design/smc_mac.sv
design/smc_access_fsm.sv
design/smc_lite_top.sv
tests/sram16_model.sv
tests/tb_smc_lite.sv

// ==== tests/sram16_model.sv ====
/*
  16-bit asynchronous SRAM model
  Byte-enabled storage for the SMC lite testbench, read combinationally
  under chip select and written on the rising edge of write enable
*/
`timescale 1ns/1ps
`include "smc_defs.svh"

module sram16_model import smc_pkg::*;
(
  input  smc_ext_bus_t           ext_bus,
  output logic [`SMC_EXT_DW-1:0] ext_rdata
);

  logic [`SMC_EXT_DW-1:0] mem [0:(1 << `SMC_EXT_AW)-1];
  logic [`SMC_EXT_AW-1:0] wr_addr;    // Held from the falling strobe
  logic [`SMC_EXT_DW-1:0] wr_data;
  logic [1:0]             wr_be_n;
  logic                   wr_pend = 1'b0;

  // Write strobe --------
  // Pins taken as we_n falls, stored as it rises
  always @(ext_bus.we_n)
  begin
    if ((ext_bus.we_n === 1'b0) && !ext_bus.cs_n)
    begin
      wr_addr = ext_bus.addr;
      wr_data = ext_bus.wdata;
      wr_be_n = ext_bus.be_n;
      wr_pend = 1'b1;
    end
    else if ((ext_bus.we_n === 1'b1) && wr_pend)
    begin
      if (!wr_be_n[0])
        mem[wr_addr][7:0] = wr_data[7:0];     // Lower byte lane
      if (!wr_be_n[1])
        mem[wr_addr][15:8] = wr_data[15:8];   // Upper byte lane
      wr_pend = 1'b0;
    end
  end

  // Bus parked low when deselected or writing
  assign ext_rdata = (!ext_bus.cs_n && ext_bus.we_n) ? mem[ext_bus.addr] : '0;

endmodule

// ==== tests/tb_smc_lite.sv ====
/*
  SMC lite testbench
  Table-driven AHB-Lite master for the controller and an SRAM model,
  with a byte-wide reference memory that predicts the read data
*/
`timescale 1ns/1ps
`include "smc_defs.svh"

module tb_smc_lite import smc_pkg::*; ();

  localparam int LIMIT = 40;                  // Cycles allowed per wait

  typedef struct packed
  {
    logic        sel;
    logic [1:0]  trans;
    logic        write;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] data;                        // hwdata, or predicted hrdata
    logic [1:0]  resp;
    logic        valid;                       // Access reaches the SRAM
  } row_t;

  logic         hclk14;
  logic         n_sys_reset14;
  logic         hsel;
  logic [31:0]  haddr;
  logic [1:0]   htrans;
  logic         hwrite;
  logic [2:0]   hsize;
  logic [31:0]  hwdata;
  logic         hready;                       // Single slave, mirrors smc_hready
  logic [31:0]  smc_hrdata;
  logic         smc_hready;
  logic [1:0]   smc_hresp;
  logic         smc_valid;
  smc_ext_bus_t ext_bus;
  logic [15:0]  ext_rdata;

  row_t         rows[$];
  string        names[$];
  logic [7:0]   ref_mem [0:255];              // Expected contents, low 256 bytes
  logic [31:0]  lfsr;
  int           mismatches;
  int           failures;
  logic         aborted;

  smc_lite_top dut0 (.*);
  sram16_model u_sram (.ext_bus(ext_bus), .ext_rdata(ext_rdata));

  initial
  begin
    hclk14 = 1'b0;
    forever #10 hclk14 = ~hclk14;
  end

  // Helpers -------------
  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int n = 0; n < 32; n++)
    begin
      lfsr = lfsr_next(lfsr);                 // One step per bit
      w    = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  // Predict response and read data from the AHB lane rules
  task automatic add_row(input string name, input logic sel, input logic [1:0] trans,
                         input logic write, input logic [2:0] size,
                         input logic [31:0] addr, input logic [31:0] data);
    row_t       r;
    logic [3:0] lanes;
    logic       aligned;
    logic       active;
    aligned = (size == 3'd0) || ((size == 3'd1) && !addr[0]) ||
              ((size == 3'd2) && (addr[1:0] == 2'b00));
    active  = sel && ((trans == `TRN_NONSEQ) || (trans == `TRN_SEQ));
    lanes   = (size == 3'd2) ? 4'hf : ((size == 3'd1) ? 4'h3 : 4'h1) << addr[1:0];
    r = '{sel: sel, trans: trans, write: write, size: size, addr: addr, data: data,
          resp: (active && !aligned) ? `RSP_ERROR : `RSP_OKAY, valid: active && aligned};
    for (int b = 0; b < 4; b++)
    begin
      if (r.valid && write && lanes[b])
        ref_mem[{addr[7:2], b[1:0]}] = data[8*b +: 8];
      else if (r.valid && !write)
        r.data[8*b +: 8] = lanes[b] ? ref_mem[{addr[7:2], b[1:0]}] : 8'h00;
    end
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Advance a clock, then mirror the slave ready onto the bus
  task automatic next_cycle();
    @(posedge hclk14);
    #1;
    hready = smc_hready;
  endtask

  // Row driver ----------
  task automatic run_row(input int i);
    row_t r;
    int   cyc;
    int   exp_cyc;
    r       = rows[i];
    exp_cyc = !r.valid ? ((r.resp == `RSP_ERROR) ? 2 : 1) :
              ((r.size == 3'd2) ? 2 : 1) * (`SMC_WAIT_STATES + 1);
    next_cycle();
    cyc = 0;
    while (!hready && (cyc < LIMIT))
    begin
      next_cycle();
      cyc++;
    end
    assert (hready) else
    begin
      $display("%s: slave never ready for the address phase", names[i]);
      failures++;
      aborted = 1'b1;
    end
    if (aborted)
      return;
    hsel   = r.sel;                           // Address phase
    htrans = r.trans;
    hwrite = r.write;
    hsize  = r.size;
    haddr  = r.addr;
    hwdata = r.write ? r.data : '0;           // Held through the data phase
    #5;
    assert (smc_valid == r.valid) else
    begin
      $display("MISMATCH %s smc_valid expected %b actual %b", names[i], r.valid, smc_valid);
      mismatches++;
    end
    next_cycle();
    hsel   = 1'b0;
    htrans = `TRN_IDLE;
    cyc    = 1;
    while (1)
    begin
      assert (smc_hresp == r.resp) else
      begin
        $display("MISMATCH %s hresp expected %h actual %h", names[i], r.resp, smc_hresp);
        mismatches++;
      end
      assert (r.valid || ext_bus.cs_n) else
      begin
        $display("%s: chip select went active for a rejected access", names[i]);
        failures++;
      end
      if (hready || (cyc >= LIMIT))
        break;
      next_cycle();
      cyc++;
    end
    assert (hready) else
    begin
      $display("%s: hready stayed low past the data phase timeout", names[i]);
      failures++;
      aborted = 1'b1;
    end
    assert (aborted || (cyc == exp_cyc)) else
    begin
      $display("MISMATCH %s cycles expected %0d actual %0d", names[i], exp_cyc, cyc);
      mismatches++;
    end
    if (r.valid && !r.write && !aborted)
      assert (smc_hrdata == r.data) else
      begin
        $display("MISMATCH %s hrdata expected %h actual %h", names[i], r.data, smc_hrdata);
        mismatches++;
      end
  endtask

  // Main ----------------
  initial
  begin
    int i;
    n_sys_reset14 = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = `TRN_IDLE;
    hwrite        = 1'b0;
    hsize         = 3'd0;
    hwdata        = '0;
    hready        = 1'b1;
    lfsr          = 32'h1353_baa8;
    mismatches    = 0;
    failures      = 0;
    aborted       = 1'b0;

    // Word round trip
    add_row("word_wr", 1, `TRN_NONSEQ, 1, 3'd2, 32'h10, rand_word());
    add_row("word_rd", 1, `TRN_NONSEQ, 0, 3'd2, 32'h10, 0);
    // Lane merge, data already in its AHB lane
    add_row("byte0_wr", 1, `TRN_NONSEQ, 1, 3'd0, 32'h20, 32'h0000_00a1);
    add_row("byte1_wr", 1, `TRN_SEQ, 1, 3'd0, 32'h21, 32'h0000_b200);
    add_row("half1_wr", 1, `TRN_NONSEQ, 1, 3'd1, 32'h22, 32'hc3d4_0000);
    add_row("merge_rd", 1, `TRN_NONSEQ, 0, 3'd2, 32'h20, 0);
    add_row("byte3_wr", 1, `TRN_NONSEQ, 1, 3'd0, 32'h23, 32'h5e00_0000);
    add_row("half0_wr", 1, `TRN_NONSEQ, 1, 3'd1, 32'h20, 32'h0000_6f70);
    add_row("byte2_rd", 1, `TRN_NONSEQ, 0, 3'd0, 32'h22, 0);
    add_row("byte1_rd", 1, `TRN_NONSEQ, 0, 3'd0, 32'h21, 0);
    add_row("half1_rd", 1, `TRN_NONSEQ, 0, 3'd1, 32'h22, 0);
    add_row("merge2_rd", 1, `TRN_NONSEQ, 0, 3'd2, 32'h20, 0);
    // Misaligned, no SRAM cycle
    add_row("mis_half_wr", 1, `TRN_NONSEQ, 1, 3'd1, 32'h21, 32'hffff_ffff);
    add_row("mis_word_wr", 1, `TRN_NONSEQ, 1, 3'd2, 32'h12, 32'hdead_beef);
    add_row("mis_word_rd", 1, `TRN_NONSEQ, 0, 3'd2, 32'h23, 0);
    add_row("post_mis_rd", 1, `TRN_NONSEQ, 0, 3'd2, 32'h20, 0);
    add_row("post_mis_rd2", 1, `TRN_NONSEQ, 0, 3'd2, 32'h10, 0);
    // Not ours or not active
    add_row("idle_wr", 1, `TRN_IDLE, 1, 3'd2, 32'h10, 32'h0bad_0bad);
    add_row("busy_wr", 1, `TRN_BUSY, 1, 3'd2, 32'h10, 32'h0bad_0bad);
    add_row("nosel_wr", 0, `TRN_NONSEQ, 1, 3'd2, 32'h10, 32'h0bad_0bad);
    add_row("post_idle_rd", 1, `TRN_NONSEQ, 0, 3'd2, 32'h10, 0);
    // Random words, read back shuffled
    for (i = 0; i < 4; i++)
      add_row($sformatf("rand_wr%0d", i), 1, `TRN_NONSEQ, 1, 3'd2, 32'h40 + 4*i, rand_word());
    add_row("rand_rd2", 1, `TRN_NONSEQ, 0, 3'd2, 32'h48, 0);
    add_row("rand_rd0", 1, `TRN_NONSEQ, 0, 3'd2, 32'h40, 0);
    add_row("rand_rd3", 1, `TRN_NONSEQ, 0, 3'd2, 32'h4c, 0);
    add_row("rand_rd1", 1, `TRN_NONSEQ, 0, 3'd2, 32'h44, 0);

    repeat (2) @(posedge hclk14);             // Reset for two cycles
    #1;
    n_sys_reset14 = 1'b1;
    hready        = smc_hready;

    for (i = 0; (i < rows.size()) && !aborted; i++)
      run_row(i);

    $display("Run complete: %0d rows, %0d mismatches, %0d other failures",
             rows.size(), mismatches, failures);
    if ((mismatches == 0) && (failures == 0))
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
